/* tb/refill_stim.txt */
// Columns, all hex: op addr waits fault abort
// op 0 instruction read, 1 data read, 2 dirty writeback; abort 1 means ERROR ends the burst
// fault 0 none, 1 bank 1 ready early, 2 bank 0 ERROR, 3 bank 1 ERROR
// Instruction refills without wait states
0 00001008 0 0 0
0 00001034 0 0 0
0 0000205c 0 0 0
// Instruction refills with wait states
0 00003014 2 0 0
0 00004000 1 0 0
// Clean data reads
1 00005010 0 0 0
1 00006038 3 0 0
// Dirty writebacks
2 00007000 0 0 0
2 00008024 2 0 0
// Mismatched readies
0 0000900c 0 1 0
1 0000a004 1 1 0
2 0000b000 0 1 0
// ERROR responses
0 0000c018 0 2 1
1 0000d01c 1 3 1

/* build.f */
+incdir+include
design/refill_pkg.sv
design/burst_if.sv
design/burst_seq.sv
design/inst_refill_port.sv
design/data_refill_port.sv
design/dual_bank_refill.sv
tb/ahb_bank_model.sv
tb/refill_tb.sv

/* Bender.yml */
package:
  name: dual_bank_refill

sources:
  - include_dirs:
      - include
    files:
      - design/refill_pkg.sv
      - design/burst_if.sv
      - design/burst_seq.sv
      - design/inst_refill_port.sv
      - design/data_refill_port.sv
      - design/dual_bank_refill.sv

  - target: test
    include_dirs:
      - include
    files:
      - tb/ahb_bank_model.sv
      - tb/refill_tb.sv

/* tb/refill_tb.sv */
`include "refill_defs.svh"

module refill_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import refill_pkg::*;

	localparam logic [31:0] seed      = 32'h1469_1a40;
	localparam int          max_tests = 32;
	localparam int          period    = 40;

	logic               clk;
	logic               rst_n;
	logic               i_inst_req, i_data_req, i_data_dirty;
	logic [`ADDR_W-1:0] i_pc, i_data_addr;
	bank_pair_t         i_wb_data;
	logic               o_inst_fill_valid, o_data_fill_valid, o_inst_err, o_data_err;
	logic [`IDX_W-1:0]  o_inst_fill_idx, o_data_fill_idx, o_wb_idx;
	bank_pair_t         o_inst_fill_data, o_data_fill_data;
	htrans_e            o_iahb_htrans, o_dahb_htrans;
	logic [`ADDR_W-1:0] o_iahb_haddr, o_dahb_haddr;
	logic               o_dahb_hwrite;
	logic [`DATA_W-1:0] o_dahb_hwdata0, o_dahb_hwdata1;
	logic               i_iahb_rdy0, i_iahb_rdy1, i_iahb_resp0, i_iahb_resp1;
	logic               i_dahb_rdy0, i_dahb_rdy1, i_dahb_resp0, i_dahb_resp1;
	logic [`DATA_W-1:0] i_iahb_rdata0, i_iahb_rdata1, i_dahb_rdata0, i_dahb_rdata1;
	// Bank model setup per side
	logic [3:0]         iwaits, dwaits;
	logic [1:0]         ifault, dfault;
	// Five words per test: op, address, waits, fault, abort expected
	logic [31:0]        stim_mem [0:5*max_tests-1];
	int                 test_total;
	int                 error_count;
	int                 failed_tests;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Word the bank models hold at a byte address
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		return xorshift(addr ^ seed);
	endfunction

	// Dirty line content on the cache side
	function automatic bank_pair_t dirty_word(input logic [`IDX_W-1:0] idx);
		bank_pair_t p;
		p.w0 = xorshift(~seed + 32'(2 * idx));
		p.w1 = xorshift(~seed + 32'(2 * idx + 1));
		return p;
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
		assert (got === exp) else begin
			$display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
			error_count++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			$display("Error at %0t ns: %s", $time, what);
			error_count++;
		end
	endtask

	// ===========================================================================
	// DUT, bank models, cache-side writeback mux
	// ===========================================================================
	dual_bank_refill dual_bank_refill_i (.*);

	assign i_wb_data = dirty_word(o_wb_idx);

	ahb_bank_model imodel (
		.clk (clk), .rst_n (rst_n),
		.i_htrans (o_iahb_htrans), .i_haddr (o_iahb_haddr),
		.i_hwrite (1'b0), .i_hwdata0 ('0), .i_hwdata1 ('0),
		.i_waits (iwaits), .i_fault (ifault),
		.o_rdy0 (i_iahb_rdy0), .o_rdy1 (i_iahb_rdy1),
		.o_resp0 (i_iahb_resp0), .o_resp1 (i_iahb_resp1),
		.o_rdata0 (i_iahb_rdata0), .o_rdata1 (i_iahb_rdata1)
	);

	ahb_bank_model dmodel (
		.clk (clk), .rst_n (rst_n),
		.i_htrans (o_dahb_htrans), .i_haddr (o_dahb_haddr),
		.i_hwrite (o_dahb_hwrite), .i_hwdata0 (o_dahb_hwdata0), .i_hwdata1 (o_dahb_hwdata1),
		.i_waits (dwaits), .i_fault (dfault),
		.o_rdy0 (i_dahb_rdy0), .o_rdy1 (i_dahb_rdy1),
		.o_resp0 (i_dahb_resp0), .o_resp1 (i_dahb_resp1),
		.o_rdata0 (i_dahb_rdata0), .o_rdata1 (i_dahb_rdata1)
	);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Run limit of 40 cycles per test
	initial begin
		wait (test_total > 0);
		#((test_total * 40 + 16) * period);
		$display("Timeout: run went past %0d cycles for %0d tests", test_total * 40, test_total);
		$display("ERRORS FOUND");
		$finish;
	end

	// ===========================================================================
	// One burst from the stimulus table
	// ===========================================================================
	task automatic run_test(input int n);
		int                op, waits, fault, abort_exp, cyc, nb, errs_seen, errs_before;
		bit                on_d, wr, done;
		logic [31:0]       addr, ha, bank0;
		logic [`IDX_W-1:0] start, exp_idx, fi;
		logic              fv, er, r0, r1, e0, e1, beat_seen, exp_err;
		htrans_e           tr;
		bank_pair_t        fd;
		op          = stim_mem[5 * n];
		addr        = stim_mem[5 * n + 1];
		waits       = stim_mem[5 * n + 2];
		fault       = stim_mem[5 * n + 3];
		abort_exp   = stim_mem[5 * n + 4];
		errs_before = error_count;
		on_d        = (op != 0);
		wr          = (op == 2);
		// Reads wrap from the missed word, writebacks start at word 0
		start       = wr ? '0 : addr[`BANK_BIT-1 -: `IDX_W];
		@(posedge clk);
		iwaits       <= on_d ? 4'd0 : waits[3:0];
		ifault       <= on_d ? 2'd0 : fault[1:0];
		dwaits       <= on_d ? waits[3:0] : 4'd0;
		dfault       <= on_d ? fault[1:0] : 2'd0;
		i_pc         <= addr;
		i_data_addr  <= addr;
		i_data_dirty <= wr;
		// Request edge
		@(posedge clk);
		if (on_d)
			i_data_req <= 1'b1;
		else
			i_inst_req <= 1'b1;
		cyc       = 0;
		nb        = 0;
		errs_seen = 0;
		done      = 0;
		while (!done && cyc < 40) begin
			@(posedge clk);
			cyc++;
			if (cyc == 1) begin
				i_inst_req <= 1'b0;
				i_data_req <= 1'b0;
			end
			@(negedge clk);
			tr = on_d ? o_dahb_htrans : o_iahb_htrans;
			ha = on_d ? o_dahb_haddr : o_iahb_haddr;
			fv = on_d ? o_data_fill_valid : o_inst_fill_valid;
			fi = on_d ? o_data_fill_idx : o_inst_fill_idx;
			fd = on_d ? o_data_fill_data : o_inst_fill_data;
			er = on_d ? o_data_err : o_inst_err;
			r0 = on_d ? i_dahb_rdy0 : i_iahb_rdy0;
			r1 = on_d ? i_dahb_rdy1 : i_iahb_rdy1;
			e0 = on_d ? i_dahb_resp0 : i_iahb_resp0;
			e1 = on_d ? i_dahb_resp1 : i_iahb_resp1;
			if (tr == IDLE) begin
				done = 1;
			end else begin
				beat_seen = r0 & r1 & ~e0 & ~e1;
				exp_idx   = start + `IDX_W'(nb);
				bank0     = {addr[`ADDR_W-1:`LINE_LSB], 1'b0, exp_idx, 2'b00};
				// Only the fault named in the table may raise an error
				case (fault)
					1: exp_err = r1 & ~r0;
					2: exp_err = e0;
					3: exp_err = e1;
					default: exp_err = 1'b0;
				endcase
				check_value("htrans", (nb == 0) ? NONSEQ : SEQ, tr);
				check_value("haddr", bank0, ha);
				check_value("err", exp_err, er);
				check_value("fill_valid", beat_seen & ~wr, fv);
				if (on_d)
					check_value("o_dahb_hwrite", wr, o_dahb_hwrite);
				if (beat_seen && !wr) begin
					check_value("fill_idx", exp_idx, fi);
					check_value("fill_data.w0", word_at(bank0), fd.w0);
					check_value("fill_data.w1", word_at(bank0 | 32'h20), fd.w1);
				end
				if (er)
					errs_seen++;
				if (beat_seen) begin
					// Accepted on the next edge
					if (nb == 7 && waits == 0 && fault == 0)
						check_value("last beat edge", 9, cyc + 1);
					nb++;
				end
			end
		end
		check_true(done, "burst did not return to IDLE within 40 cycles");
		if (abort_exp != 0)
			check_true(nb < `BEATS, "burst with an ERROR response ran to the end");
		else
			check_value("beat count", `BEATS, nb);
		if (fault != 0)
			check_true(errs_seen > 0, "injected fault gave no error pulse");
		if (wr && abort_exp == 0) begin
			check_value("write beats", `BEATS, dmodel.wr_cnt);
			for (int k = 0; k < `BEATS; k++) begin
				check_value("write idx", k, dmodel.wr_idx[k]);
				check_value("o_dahb_hwdata", dirty_word(`IDX_W'(k)), dmodel.wr_data[k]);
			end
		end
		if (error_count != errs_before)
			failed_tests++;
		$display("Test %0d op %0d addr %h waits %0d fault %0d: %s", n, op, addr, waits, fault,
			(error_count == errs_before) ? "pass" : "fail");
	endtask

	// ===========================================================================
	// Main sequence
	// ===========================================================================
	initial begin
		rst_n        = 1'b0;
		i_inst_req   = 1'b0;
		i_data_req   = 1'b0;
		i_data_dirty = 1'b0;
		i_pc         = '0;
		i_data_addr  = '0;
		iwaits       = '0;
		dwaits       = '0;
		ifault       = '0;
		dfault       = '0;
		error_count  = 0;
		failed_tests = 0;
		test_total   = 0;
		// All ones marks the end of the table
		for (int k = 0; k < 5 * max_tests; k++)
			stim_mem[k] = '1;
		$readmemh("tb/refill_stim.txt", stim_mem);
		while (test_total < max_tests && stim_mem[5 * test_total] != '1)
			test_total++;
		repeat (7) @(posedge clk);
		// Outputs while still in reset
		@(negedge clk);
		check_value("o_iahb_htrans", IDLE, o_iahb_htrans);
		check_value("o_dahb_htrans", IDLE, o_dahb_htrans);
		check_value("o_inst_fill_valid", 0, o_inst_fill_valid);
		check_value("o_data_fill_valid", 0, o_data_fill_valid);
		check_value("o_inst_err", 0, o_inst_err);
		check_value("o_data_err", 0, o_data_err);
		check_value("o_dahb_hwrite", 0, o_dahb_hwrite);
		@(posedge clk);
		rst_n <= 1'b1;
		check_true(test_total > 0, "stimulus file gave no tests");
		for (int n = 0; n < test_total; n++)
			run_test(n);
		repeat (2) @(posedge clk);
		$display("Tests run %0d, tests failed %0d, checks failed %0d",
			test_total, failed_tests, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* tb/ahb_bank_model.sv */
`include "refill_defs.svh"

module ahb_bank_model (
	input  logic                clk,
	input  logic                rst_n,
	// Shared request from one refill port
	input  refill_pkg::htrans_e i_htrans,
	input  logic [`ADDR_W-1:0]  i_haddr,
	input  logic                i_hwrite,
	input  logic [`DATA_W-1:0]  i_hwdata0,
	input  logic [`DATA_W-1:0]  i_hwdata1,
	// Per-test behavior
	input  logic [3:0]          i_waits,
	input  logic [1:0]          i_fault,
	// Bank pair answers
	output logic                o_rdy0,
	output logic                o_rdy1,
	output logic                o_resp0,
	output logic                o_resp1,
	output logic [`DATA_W-1:0]  o_rdata0,
	output logic [`DATA_W-1:0]  o_rdata1
);
	timeunit 1ns;
	timeprecision 100ps;
	import refill_pkg::*;

	localparam logic [31:0] seed       = 32'h1469_1a40;
	// Beat number that carries the injected fault
	localparam int          fault_beat = 2;

	int                wcnt;
	int                nbeat;
	bit                faulted;
	logic              active;
	logic              acc;
	// Captured write beats
	logic [`IDX_W-1:0] wr_idx [0:`BEATS-1];
	logic [63:0]       wr_data [0:`BEATS-1];
	int                wr_cnt;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// ===========================================================================
	// Memory contents, read without latency
	// ===========================================================================
	assign o_rdata0 = xorshift({i_haddr[`ADDR_W-1:`LINE_LSB], 1'b0, i_haddr[`BANK_BIT-1:0]} ^ seed);
	assign o_rdata1 = xorshift({i_haddr[`ADDR_W-1:`LINE_LSB], 1'b1, i_haddr[`BANK_BIT-1:0]} ^ seed);

	assign active = (i_htrans == NONSEQ) || (i_htrans == SEQ);
	// Beat taken on the coming edge
	assign acc    = active & o_rdy0 & o_rdy1 & ~o_resp0 & ~o_resp1;

	// ===========================================================================
	// Ready and response generation
	// ===========================================================================
	always @(posedge clk or negedge rst_n) begin : respond
		int wnext;
		int bnext;
		bit ready;
		if (!rst_n) begin
			o_rdy0  <= 1'b0;
			o_rdy1  <= 1'b0;
			o_resp0 <= 1'b0;
			o_resp1 <= 1'b0;
			wcnt    <= 0;
			nbeat   <= 0;
			faulted <= 1'b0;
			wr_cnt  <= 0;
		end else begin
			// Wait count restarts after every accepted beat
			if (!active) begin
				wnext = 0;
				bnext = 0;
			end else if (acc) begin
				wnext = 0;
				bnext = nbeat + 1;
			end else begin
				wnext = wcnt + 1;
				bnext = nbeat;
			end
			ready = (wnext >= i_waits);
			wcnt  <= wnext;
			nbeat <= bnext;
			o_rdy0  <= ready;
			o_rdy1  <= ready;
			o_resp0 <= 1'b0;
			o_resp1 <= 1'b0;
			if (!active) begin
				faulted <= 1'b0;
				// Capture restarts with each burst
				wr_cnt  <= 0;
			end
			// One fault per burst, in place of the third beat
			if (ready && active && !faulted && bnext == fault_beat) begin
				case (i_fault)
					2'd1: begin
						// Bank 1 ready one cycle ahead of bank 0
						o_rdy0  <= 1'b0;
						faulted <= 1'b1;
					end
					2'd2: begin
						o_resp0 <= 1'b1;
						faulted <= 1'b1;
					end
					2'd3: begin
						o_resp1 <= 1'b1;
						faulted <= 1'b1;
					end
					default: ;
				endcase
			end
			if (acc && i_hwrite) begin
				wr_idx[nbeat]  <= i_haddr[`BANK_BIT-1 -: `IDX_W];
				wr_data[nbeat] <= {i_hwdata1, i_hwdata0};
				wr_cnt         <= nbeat + 1;
			end
		end
	end

endmodule

/* design/dual_bank_refill.sv */
`include "refill_defs.svh"

module dual_bank_refill (
	input  logic                   clk,
	input  logic                   rst_n,
	// Instruction cache side
	input  logic                   i_inst_req,
	input  logic [`ADDR_W-1:0]     i_pc,
	output logic                   o_inst_fill_valid,
	output logic [`IDX_W-1:0]      o_inst_fill_idx,
	output refill_pkg::bank_pair_t o_inst_fill_data,
	output logic                   o_inst_err,
	// Data cache side
	input  logic                   i_data_req,
	input  logic                   i_data_dirty,
	input  logic [`ADDR_W-1:0]     i_data_addr,
	input  refill_pkg::bank_pair_t i_wb_data,
	output logic [`IDX_W-1:0]      o_wb_idx,
	output logic                   o_data_fill_valid,
	output logic [`IDX_W-1:0]      o_data_fill_idx,
	output refill_pkg::bank_pair_t o_data_fill_data,
	output logic                   o_data_err,
	// Instruction bank pair
	output refill_pkg::htrans_e    o_iahb_htrans,
	output logic [`ADDR_W-1:0]     o_iahb_haddr,
	input  logic                   i_iahb_rdy0,
	input  logic                   i_iahb_rdy1,
	input  logic                   i_iahb_resp0,
	input  logic                   i_iahb_resp1,
	input  logic [`DATA_W-1:0]     i_iahb_rdata0,
	input  logic [`DATA_W-1:0]     i_iahb_rdata1,
	// Data bank pair
	output refill_pkg::htrans_e    o_dahb_htrans,
	output logic [`ADDR_W-1:0]     o_dahb_haddr,
	output logic                   o_dahb_hwrite,
	output logic [`DATA_W-1:0]     o_dahb_hwdata0,
	output logic [`DATA_W-1:0]     o_dahb_hwdata1,
	input  logic                   i_dahb_rdy0,
	input  logic                   i_dahb_rdy1,
	input  logic                   i_dahb_resp0,
	input  logic                   i_dahb_resp1,
	input  logic [`DATA_W-1:0]     i_dahb_rdata0,
	input  logic [`DATA_W-1:0]     i_dahb_rdata1
);
	import refill_pkg::*;

	bank_pair_t inst_rdata;
	bank_pair_t data_rdata;
	bank_pair_t data_wdata;

	// Pack flat bank buses into pairs
	assign inst_rdata = '{w1: i_iahb_rdata1, w0: i_iahb_rdata0};
	assign data_rdata = '{w1: i_dahb_rdata1, w0: i_dahb_rdata0};

	assign o_dahb_hwdata0 = data_wdata.w0;
	assign o_dahb_hwdata1 = data_wdata.w1;

	// ===========================================================================
	// Instruction refill
	// ===========================================================================
	inst_refill_port u_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_req        (i_inst_req),
		.i_pc         (i_pc),
		.i_rdy0       (i_iahb_rdy0),
		.i_rdy1       (i_iahb_rdy1),
		.i_resp0      (i_iahb_resp0),
		.i_resp1      (i_iahb_resp1),
		.i_rdata      (inst_rdata),
		.o_htrans     (o_iahb_htrans),
		.o_haddr      (o_iahb_haddr),
		.o_fill_valid (o_inst_fill_valid),
		.o_fill_idx   (o_inst_fill_idx),
		.o_fill_data  (o_inst_fill_data),
		.o_err        (o_inst_err)
	);

	// ===========================================================================
	// Data refill and writeback
	// ===========================================================================
	data_refill_port u_data (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_req        (i_data_req),
		.i_dirty      (i_data_dirty),
		.i_addr       (i_data_addr),
		.i_wb_data    (i_wb_data),
		.i_rdy0       (i_dahb_rdy0),
		.i_rdy1       (i_dahb_rdy1),
		.i_resp0      (i_dahb_resp0),
		.i_resp1      (i_dahb_resp1),
		.i_rdata      (data_rdata),
		.o_htrans     (o_dahb_htrans),
		.o_haddr      (o_dahb_haddr),
		.o_hwrite     (o_dahb_hwrite),
		.o_hwdata     (data_wdata),
		.o_wb_idx     (o_wb_idx),
		.o_fill_valid (o_data_fill_valid),
		.o_fill_idx   (o_data_fill_idx),
		.o_fill_data  (o_data_fill_data),
		.o_err        (o_data_err)
	);

endmodule

/* design/data_refill_port.sv */
`include "refill_defs.svh"

module data_refill_port (
	input  logic                   clk,
	input  logic                   rst_n,
	// Cache side
	input  logic                   i_req,
	input  logic                   i_dirty,
	input  logic [`ADDR_W-1:0]     i_addr,
	// Dirty line words, picked by o_wb_idx
	input  refill_pkg::bank_pair_t i_wb_data,
	// Bank pair responses
	input  logic                   i_rdy0,
	input  logic                   i_rdy1,
	input  logic                   i_resp0,
	input  logic                   i_resp1,
	input  refill_pkg::bank_pair_t i_rdata,
	// Shared request to both banks
	output refill_pkg::htrans_e    o_htrans,
	output logic [`ADDR_W-1:0]     o_haddr,
	output logic                   o_hwrite,
	output refill_pkg::bank_pair_t o_hwdata,
	// Writeback word select
	output logic [`IDX_W-1:0]      o_wb_idx,
	// Line fill toward the cache
	output logic                   o_fill_valid,
	output logic [`IDX_W-1:0]      o_fill_idx,
	output refill_pkg::bank_pair_t o_fill_data,
	output logic                   o_err
);

	burst_if bus ();

	logic [`IDX_W-1:0] rd_start;

	// ===========================================================================
	// Burst request
	// ===========================================================================
	// Read wraps from the missed word
	assign rd_start = i_addr[`BANK_BIT-1 -: `IDX_W];

	assign bus.req       = i_req;
	// Dirty replace always writes from word 0
	assign bus.start_idx = i_dirty ? '0 : rd_start;
	assign bus.write     = i_dirty;

	burst_seq u_seq (
		.i_clk   (clk),
		.rst_n   (rst_n),
		.i_rdy0  (i_rdy0),
		.i_rdy1  (i_rdy1),
		.i_resp0 (i_resp0),
		.i_resp1 (i_resp1),
		.o_err   (o_err),
		.bus     (bus.seq)
	);

	// ===========================================================================
	// Bus side
	// ===========================================================================
	assign o_htrans = bus.htrans;
	assign o_haddr  = {i_addr[`ADDR_W-1:`LINE_LSB], 1'b0, bus.idx, 2'b00};
	// Direction held for the whole burst
	assign o_hwrite = bus.dir;

	// ===========================================================================
	// Writeback data
	// ===========================================================================
	// Cache muxes the line word for the current index
	assign o_wb_idx = bus.idx;
	assign o_hwdata = i_wb_data;

	// ===========================================================================
	// Line fill
	// ===========================================================================
	// No fill strobes while writing back
	assign o_fill_valid = bus.beat & ~bus.dir;
	assign o_fill_idx   = bus.idx;
	assign o_fill_data  = i_rdata;

endmodule

/* design/inst_refill_port.sv */
`include "refill_defs.svh"

module inst_refill_port (
	input  logic                   clk,
	input  logic                   rst_n,
	// Cache side
	input  logic                   i_req,
	input  logic [`ADDR_W-1:0]     i_pc,
	// Bank pair responses
	input  logic                   i_rdy0,
	input  logic                   i_rdy1,
	input  logic                   i_resp0,
	input  logic                   i_resp1,
	input  refill_pkg::bank_pair_t i_rdata,
	// Shared request to both banks
	output refill_pkg::htrans_e    o_htrans,
	output logic [`ADDR_W-1:0]     o_haddr,
	// Line fill toward the cache
	output logic                   o_fill_valid,
	output logic [`IDX_W-1:0]      o_fill_idx,
	output refill_pkg::bank_pair_t o_fill_data,
	output logic                   o_err
);

	burst_if bus ();

	// ===========================================================================
	// Read-only burst request
	// ===========================================================================
	assign bus.req       = i_req;
	// Critical word first
	assign bus.start_idx = i_pc[`BANK_BIT-1 -: `IDX_W];
	assign bus.write     = 1'b0;

	burst_seq u_seq (
		.i_clk   (clk),
		.rst_n   (rst_n),
		.i_rdy0  (i_rdy0),
		.i_rdy1  (i_rdy1),
		.i_resp0 (i_resp0),
		.i_resp1 (i_resp1),
		.o_err   (o_err),
		.bus     (bus.seq)
	);

	// Bank bit left at zero, slaves decode their own bank
	assign o_htrans = bus.htrans;
	assign o_haddr  = {i_pc[`ADDR_W-1:`LINE_LSB], 1'b0, bus.idx, 2'b00};

	// One strobe per accepted beat
	assign o_fill_valid = bus.beat;
	assign o_fill_idx   = bus.idx;
	assign o_fill_data  = i_rdata;

endmodule

/* design/burst_seq.sv */
`include "refill_defs.svh"

module burst_seq (
	input  logic i_clk,
	input  logic rst_n,
	input  logic i_rdy0,
	input  logic i_rdy1,
	input  logic i_resp0,
	input  logic i_resp1,
	output logic o_err,
	burst_if.seq bus
);
	import refill_pkg::*;

	htrans_e           state;
	htrans_e           state_nxt;
	logic [`IDX_W-1:0] cnt;
	logic [`IDX_W-1:0] idx_q;
	logic              dir_q;
	logic              active;
	logic              both_rdy;
	logic              one_rdy;
	logic              resp_err;
	logic              launch;

	// ===========================================================================
	// Beat and fault decode
	// ===========================================================================
	assign active   = (state == NONSEQ) || (state == SEQ);
	assign both_rdy = i_rdy0 & i_rdy1;
	// Banks disagree on ready
	assign one_rdy  = i_rdy0 ^ i_rdy1;
	// Any ready bank answering ERROR
	assign resp_err = (i_rdy0 & i_resp0) | (i_rdy1 & i_resp1);

	// Both ready and both OKAY
	assign bus.beat = active & both_rdy & ~resp_err;
	assign bus.last = bus.beat & (cnt == `IDX_W'(`BEATS - 1));
	assign o_err    = active & (one_rdy | resp_err);

	// New burst from IDLE, or back to back after the eighth beat
	assign launch = bus.req & ((state == IDLE) | bus.last);

	assign bus.htrans = state;
	assign bus.idx    = idx_q;
	assign bus.dir    = dir_q;

	// ===========================================================================
	// Transfer state
	// ===========================================================================
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (bus.req)
					state_nxt = NONSEQ;
			end
			NONSEQ, SEQ: begin
				// Error response aborts the line
				if (resp_err)
					state_nxt = IDLE;
				else if (bus.last)
					state_nxt = bus.req ? NONSEQ : IDLE;
				else if (bus.beat)
					state_nxt = SEQ;
				// Wait states and mismatched readies hold here
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge rst_n) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// ===========================================================================
	// Beat counter, wrap index, direction
	// ===========================================================================
	always_ff @(posedge i_clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt   <= '0;
			idx_q <= `IDX_W'(`RESET_IDX);
			dir_q <= 1'b0;
		end else if (launch) begin
			// Sample start point and direction
			cnt   <= '0;
			idx_q <= bus.start_idx;
			dir_q <= bus.write;
		end else if (active && resp_err) begin
			cnt <= '0;
		end else if (bus.beat) begin
			cnt   <= bus.last ? '0 : cnt + 1'b1;
			// Wraps modulo 8 by width
			idx_q <= idx_q + 1'b1;
		end
	end

endmodule

/* design/burst_if.sv */
`include "refill_defs.svh"

interface burst_if;
	import refill_pkg::*;

	// Port side request
	logic              req;
	logic [`IDX_W-1:0] start_idx;
	logic              write;

	// Sequencer status
	htrans_e           htrans;
	logic [`IDX_W-1:0] idx;
	logic              beat;
	logic              last;
	logic              dir;

	// Port logic that owns the burst
	modport port (
		output req, start_idx, write,
		input  htrans, idx, beat, last, dir
	);

	// Burst sequencer
	modport seq (
		input  req, start_idx, write,
		output htrans, idx, beat, last, dir
	);

endinterface

/* design/refill_pkg.sv */
`include "refill_defs.svh"

package refill_pkg;

	// ===========================================================================
	// AHB transfer state
	// ===========================================================================
	// Encoding matches HTRANS on the bus
	// BUSY is never entered by the sequencer
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	// ===========================================================================
	// Refill payload
	// ===========================================================================
	// One word from each bank of a pair
	// w0 from the bank with address bit 5 clear, w1 from the other
	// w0 sits in the low half
	typedef struct packed {
		logic [`DATA_W-1:0] w1;
		logic [`DATA_W-1:0] w0;
	} bank_pair_t;

endpackage

/* include/refill_defs.svh */
`ifndef REFILL_DEFS_SVH
`define REFILL_DEFS_SVH

// ===========================================================================
// Bus widths
// ===========================================================================
`define ADDR_W 32
`define DATA_W 32

// ===========================================================================
// Burst and line geometry
// ===========================================================================
// WRAP8 burst, one word per bank per beat
`define BEATS 8
`define IDX_W 3
// Line base starts above the bank bit
`define LINE_LSB 6
// Bit 5 picks bank 1
`define BANK_BIT 5

// Wrap index after reset
`define RESET_IDX 0

`endif
